// ==== design/procTypes.sv ====
/* ISA types for the 16-bit pipelined core */

package procTypes;

  typedef logic [15:0] word;   // data value or instruction
  typedef logic [2:0]  regIdx; // one of eight registers
  typedef logic [7:0]  pcAddr; // widest instruction address

  typedef enum logic [3:0] {
    opNop  = 4'h0,
    opAdd  = 4'h1,
    opSub  = 4'h2,
    opAnd  = 4'h3,
    opXor  = 4'h4,
    opAddi = 4'h5,
    opLi   = 4'h6,
    opBeqz = 4'h7,
    opHalt = 4'h8
  } opcode; // 4'h9 and up are illegal

  // instruction field layout
  localparam int opLsb = 12;
  localparam int opW   = 4;
  localparam int rdLsb = 9;
  localparam int rsLsb = 6;
  localparam int rtLsb = 3;
  localparam int regW  = 3;

  // immediates both start at bit 0
  localparam int imm6W = 6;
  localparam int imm9W = 9; // LI only

endpackage

// ==== design/pipeTypes.sv ====
/* pipeline stage records */

package pipeTypes;

  // fetch to decode, 25 bits
  typedef struct packed {
    logic             valid;
    procTypes::pcAddr pc;
    procTypes::word   instr;
  } fetchPkt;

  // decode to execute
  typedef struct packed {
    logic             valid;
    procTypes::pcAddr pc;
    procTypes::opcode op;
    procTypes::regIdx rd;
    procTypes::word   opA;     // rs value
    procTypes::word   opB;     // rt value
    procTypes::word   imm;     // already sign extended
    logic             illegal;
  } decodePkt;

  // one register write, also reported at the top
  typedef struct packed {
    logic             strobe;
    procTypes::regIdx rd;
    procTypes::word   data;
  } wbPkt;

endpackage

// ==== design/fetchUnit.sv ====
/* instruction fetch stage */
`timescale 1ns/100ps

module fetchUnit #(
  parameter int imemDepth = 64
) (
  input  logic               clk,
  input  logic               rstN,
  input  logic               loadEn,
  input  procTypes::pcAddr   loadAddr,
  input  procTypes::word     loadData,
  input  logic               flush,
  input  procTypes::pcAddr   branchTarget,
  input  logic               halted,
  output pipeTypes::fetchPkt fetchOut
);

  localparam int idxW = $clog2(imemDepth);

  procTypes::word   imem [imemDepth];
  procTypes::pcAddr pc;
  procTypes::pcAddr pcInc;

  // program loading happens while the core is held in reset
  always_ff @(posedge clk) begin
    if (loadEn) begin
      imem[loadAddr[idxW-1:0]] <= loadData;
    end
  end

  assign pcInc = (int'(pc) == imemDepth - 1) ? '0 : pc + 1'b1; // wrap at depth

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (flush) begin
      pc <= branchTarget; // taken branch from execute
    end else if (!halted) begin
      pc <= pcInc;
    end
  end

  // async read at pc, registered into the IF/ID packet
  always_ff @(posedge clk) begin
    fetchOut <= '{valid: !flush && !halted, pc: pc, instr: imem[pc[idxW-1:0]]};
    if (!rstN) begin
      fetchOut.valid <= 1'b0;
    end
  end

  pcInRange: assert property (@(posedge clk) disable iff (!rstN)
    int'(pc) < imemDepth)
    else $error("pc left the instruction memory");

endmodule

// ==== design/regFile.sv ====
/* register file */
`timescale 1ns/100ps

module regFile (
  input  logic             clk,
  input  logic             rstN,
  input  procTypes::regIdx rdAddrA,
  input  procTypes::regIdx rdAddrB,
  output procTypes::word   rdDataA,
  output procTypes::word   rdDataB,
  input  pipeTypes::wbPkt  wb
);

  localparam int numRegs = 2 ** $bits(procTypes::regIdx);

  procTypes::word regs [numRegs];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wb.strobe) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // write-through: a read in the write cycle already sees the new value
  assign rdDataA = (wb.strobe && wb.rd == rdAddrA) ? wb.data : regs[rdAddrA];
  assign rdDataB = (wb.strobe && wb.rd == rdAddrB) ? wb.data : regs[rdAddrB];

  wbDataKnown: assert property (@(posedge clk) disable iff (!rstN)
    wb.strobe |-> !$isunknown(wb.data))
    else $error("register write with unknown data");

endmodule

// ==== design/decodeUnit.sv ====
/* instruction decode stage */
`timescale 1ns/100ps

module decodeUnit (
  input  logic                clk,
  input  logic                rstN,
  input  logic                flush,
  input  pipeTypes::fetchPkt  fetchIn,
  input  pipeTypes::wbPkt     wb,
  output pipeTypes::decodePkt decodeOut
);

  procTypes::word      instr;
  procTypes::opcode    op;
  procTypes::regIdx    rs;
  procTypes::regIdx    rt;
  procTypes::word      rsData;
  procTypes::word      rtData;
  procTypes::word      immExt;
  logic                legal;
  pipeTypes::decodePkt pktNext;
  pipeTypes::decodePkt pktQ;
  procTypes::regIdx    rsQ;
  procTypes::regIdx    rtQ;

  assign instr = fetchIn.instr;
  assign op    = procTypes::opcode'(instr[procTypes::opLsb +: procTypes::opW]);
  assign rs    = instr[procTypes::rsLsb +: procTypes::regW];
  assign rt    = instr[procTypes::rtLsb +: procTypes::regW];

  always_comb begin
    case (op)
      procTypes::opNop, procTypes::opAdd, procTypes::opSub,
      procTypes::opAnd, procTypes::opXor, procTypes::opAddi,
      procTypes::opLi, procTypes::opBeqz, procTypes::opHalt: legal = 1'b1;
      default: legal = 1'b0;
    endcase
  end

  // LI takes imm9, everything else imm6
  assign immExt = (op == procTypes::opLi)
    ? {{($bits(procTypes::word) - procTypes::imm9W){instr[procTypes::imm9W-1]}},
       instr[procTypes::imm9W-1:0]}
    : {{($bits(procTypes::word) - procTypes::imm6W){instr[procTypes::imm6W-1]}},
       instr[procTypes::imm6W-1:0]};

  regFile regs (
    .clk    (clk),
    .rstN   (rstN),
    .rdAddrA(rs),
    .rdAddrB(rt),
    .rdDataA(rsData),
    .rdDataB(rtData),
    .wb     (wb)
  );

  always_comb begin
    pktNext.valid   = fetchIn.valid && !flush; // squash on taken branch
    pktNext.pc      = fetchIn.pc;
    pktNext.op      = op;
    pktNext.rd      = instr[procTypes::rdLsb +: procTypes::regW];
    pktNext.opA     = rsData;
    pktNext.opB     = rtData;
    pktNext.imm     = immExt;
    pktNext.illegal = !legal;
  end

  always_ff @(posedge clk) begin
    pktQ <= pktNext;
    rsQ  <= rs;
    rtQ  <= rt;
    if (!rstN) begin
      pktQ.valid <= 1'b0;
    end
  end

  // forward from the instruction just ahead, its result lands in wb one cycle late
  always_comb begin
    decodeOut = pktQ;
    if (wb.strobe && wb.rd == rsQ) decodeOut.opA = wb.data;
    if (wb.strobe && wb.rd == rtQ) decodeOut.opB = wb.data;
  end

endmodule

// ==== design/executeUnit.sv ====
/* execute and writeback stage */
`timescale 1ns/100ps

module executeUnit (
  input  logic                clk,
  input  logic                rstN,
  input  pipeTypes::decodePkt decodeIn,
  output pipeTypes::wbPkt     wb,
  output logic                flush,
  output procTypes::pcAddr    branchTarget,
  output logic                halted,
  output logic                err
);

  typedef enum logic {
    stRunning,
    stStopped
  } exState;

  exState         state;
  procTypes::word aluOut;
  logic           writes;
  logic           active;
  logic           doHalt;

  assign active = (state == stRunning) && decodeIn.valid;

  always_comb begin
    aluOut = '0;
    writes = 1'b0;
    case (decodeIn.op)
      procTypes::opAdd: begin
        aluOut = decodeIn.opA + decodeIn.opB; // wraps at 16 bits
        writes = 1'b1;
      end
      procTypes::opSub: begin
        aluOut = decodeIn.opA - decodeIn.opB;
        writes = 1'b1;
      end
      procTypes::opAnd: begin
        aluOut = decodeIn.opA & decodeIn.opB;
        writes = 1'b1;
      end
      procTypes::opXor: begin
        aluOut = decodeIn.opA ^ decodeIn.opB;
        writes = 1'b1;
      end
      procTypes::opAddi: begin
        aluOut = decodeIn.opA + decodeIn.imm;
        writes = 1'b1;
      end
      procTypes::opLi: begin
        aluOut = decodeIn.imm;
        writes = 1'b1;
      end
      default: ; // nop, beqz, halt and illegal write nothing
    endcase
  end

  // branch resolves here, fetch and decode squash on the next edge
  assign flush = active && !decodeIn.illegal && decodeIn.op == procTypes::opBeqz &&
                 decodeIn.opA == '0;
  assign branchTarget = decodeIn.pc + 1'b1 + procTypes::pcAddr'(decodeIn.imm);

  assign doHalt = active && (decodeIn.illegal || decodeIn.op == procTypes::opHalt);

  always_ff @(posedge clk) begin
    wb.rd   <= decodeIn.rd;
    wb.data <= aluOut;
    if (!rstN) begin
      state     <= stRunning;
      wb.strobe <= 1'b0;
      err       <= 1'b0;
    end else begin
      wb.strobe <= active && writes && !decodeIn.illegal;
      if (doHalt) begin
        state <= stStopped; // no way back short of reset
      end
      if (active && decodeIn.illegal) begin
        err <= 1'b1; // sticky
      end
    end
  end

  assign halted = (state == stStopped);

  noWriteWhenStopped: assert property (@(posedge clk) disable iff (!rstN)
    halted |-> !wb.strobe)
    else $error("register write after halt");

  // both squashed slots behind a taken branch must stay silent
  flushSilencesWb: assert property (@(posedge clk) disable iff (!rstN)
    flush |=> ##1 (!wb.strobe) [*2])
    else $error("write retired across a taken branch");

endmodule

// ==== design/proc.sv ====
/* three-stage 16-bit processor */
`timescale 1ns/100ps

module proc #(
  parameter int imemDepth = 64
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             loadEn,
  input  procTypes::pcAddr loadAddr,
  input  procTypes::word   loadData,
  output logic             wbStrobe,
  output procTypes::regIdx wbReg,
  output procTypes::word   wbData,
  output logic             halted,
  output logic             err
);

  pipeTypes::fetchPkt  ifId;
  pipeTypes::decodePkt idEx;
  pipeTypes::wbPkt     wb;
  logic                flush;
  procTypes::pcAddr    branchTarget;

  fetchUnit #(
    .imemDepth(imemDepth)
  ) instructionFetch (
    .clk         (clk),
    .rstN        (rstN),
    .loadEn      (loadEn),
    .loadAddr    (loadAddr),
    .loadData    (loadData),
    .flush       (flush),
    .branchTarget(branchTarget),
    .halted      (halted),  // freezes pc
    .fetchOut    (ifId)
  );

  decodeUnit instructionDecode (
    .clk      (clk),
    .rstN     (rstN),
    .flush    (flush),
    .fetchIn  (ifId),
    .wb       (wb),         // regfile write and forward
    .decodeOut(idEx)
  );

  executeUnit instructionExecute (
    .clk         (clk),
    .rstN        (rstN),
    .decodeIn    (idEx),
    .wb          (wb),
    .flush       (flush),
    .branchTarget(branchTarget),
    .halted      (halted),
    .err         (err)
  );

  // retirement report
  assign wbStrobe = wb.strobe;
  assign wbReg    = wb.rd;
  assign wbData   = wb.data;

endmodule

// ==== tests/procTb.sv ====
/* pipelined core testbench */
`timescale 1ns/100ps

module procTb;

  typedef struct packed {
    procTypes::regIdx rd;
    procTypes::word   data;
  } regWrite;

  logic             clk;
  logic             rstN;
  logic             loadEn;
  procTypes::pcAddr loadAddr;
  procTypes::word   loadData;
  logic             wbStrobe;
  procTypes::regIdx wbReg;
  procTypes::word   wbData;
  logic             halted;
  logic             err;

  procTypes::word prog [$];
  regWrite        expQ [$];  // expected writes in retirement order
  logic [31:0]    lcgState;
  int             errCount;
  int             testCount;
  int             failCount;
  int             cycleLimit;
  int             runCycles;

  proc #(
    .imemDepth(64)
  ) u_proc (
    .clk     (clk),
    .rstN    (rstN),
    .loadEn  (loadEn),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .wbStrobe(wbStrobe),
    .wbReg   (wbReg),
    .wbData  (wbData),
    .halted  (halted),
    .err     (err)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function logic [15:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[30:15]; // low bits of the LCG repeat too soon
  endfunction

  function automatic procTypes::word aluWord(procTypes::opcode op, int rd, int rs, int rt);
    return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
  endfunction

  function automatic procTypes::word immWord(procTypes::opcode op, int rd, int rs, int imm);
    return {op, 3'(rd), 3'(rs), 6'(imm)};
  endfunction

  function automatic procTypes::word liWord(int rd, int imm);
    return {procTypes::opLi, 3'(rd), 9'(imm)};
  endfunction

  // ISA interpreter, fills expQ and returns the expected err
  function automatic bit modelProgram();
    procTypes::word regs [8];
    procTypes::word instr;
    procTypes::word imm6;
    procTypes::word a;
    procTypes::word b;
    procTypes::word val;
    int             pc;
    int             steps;
    bit             stop;
    bit             isErr;
    regs = '{default: '0};
    pc = 0;
    steps = 0;
    stop = 1'b0;
    isErr = 1'b0;
    while (!stop && steps < 1000 && pc < prog.size()) begin
      instr = prog[pc];
      imm6 = {{10{instr[5]}}, instr[5:0]};
      a = regs[instr[8:6]];
      b = regs[instr[5:3]];
      pc++;
      steps++;
      case (instr[15:12])
        procTypes::opAdd:  val = a + b;
        procTypes::opSub:  val = a - b;
        procTypes::opAnd:  val = a & b;
        procTypes::opXor:  val = a ^ b;
        procTypes::opAddi: val = a + imm6;
        procTypes::opLi:   val = {{7{instr[8]}}, instr[8:0]};
        default:           val = '0;
      endcase
      if (instr[15:12] >= 4'h1 && instr[15:12] <= 4'h6) begin // ADD through LI write rd
        regs[instr[11:9]] = val;
        expQ.push_back('{rd: instr[11:9], data: val});
      end
      if (instr[15:12] == procTypes::opBeqz && a == '0) pc = pc + int'($signed(imm6));
      if (instr[15:12] == procTypes::opHalt || instr[15:12] > 4'h8) stop = 1'b1;
      isErr = instr[15:12] > 4'h8;
    end
    return isErr;
  endfunction

  task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errCount++;
    end
  endtask

  // load under reset, release, and wait for the core to stop
  task automatic runProgram(input string name);
    int errsBefore;
    bit expErr;
    errsBefore = errCount;
    rstN = 1'b0;
    expQ.delete();
    for (int i = 0; i < prog.size(); i++) begin
      loadEn = 1'b1;
      loadAddr = 8'(i);
      loadData = prog[i];
      @(negedge clk);
    end
    loadEn = 1'b0;
    repeat (5) @(negedge clk);
    expErr = modelProgram();
    cycleLimit += 3 * prog.size() + 20; // forward branches only
    rstN = 1'b1;
    while (halted !== 1'b1) @(negedge clk);
    repeat (4) @(negedge clk);  // any late write would show up here
    checkValue("pending writes", 16'(expQ.size()), 16'd0);
    checkValue("err", 16'(err), 16'(expErr));
    testCount++;
    if (errCount != errsBefore) failCount++;
    $display("test %0d %s: %s", testCount, name, (errCount == errsBefore) ? "passed" : "FAILED");
  endtask

  initial begin : monitor
    regWrite e;
    forever begin
      @(negedge clk);
      if (wbStrobe === 1'b1) begin
        if (expQ.size() == 0) begin
          $display("unexpected write to r%0d at %0t ns", wbReg, $time);
          errCount++;
        end else begin
          e = expQ.pop_front();
          checkValue("wbReg", 16'(wbReg), 16'(e.rd));
          checkValue("wbData", wbData, e.data);
        end
      end
    end
  end

  initial begin : watchdog
    runCycles = 0;
    while (runCycles <= cycleLimit) begin
      @(posedge clk);
      if (rstN === 1'b1) runCycles++;
    end
    $display("timeout: the core did not halt within %0d run cycles", cycleLimit);
    $display("Something failed");
    $finish;
  end

  initial begin : tests
    logic [15:0] r;
    logic [15:0] s;
    int          skip;
    rstN = 1'b0;
    loadEn = 1'b0;
    loadAddr = '0;
    loadData = '0;
    lcgState = 32'd60;
    errCount = 0;
    testCount = 0;
    failCount = 0;
    cycleLimit = 0;
    @(negedge clk);

    prog.delete();
    repeat (3) begin
      r = nextRand();
      s = nextRand();
      prog.push_back(liWord(1, r[8:0]));
      prog.push_back(immWord(procTypes::opAddi, 1, 1, r[14:9]));
      prog.push_back(liWord(2, s[8:0]));
      prog.push_back(immWord(procTypes::opAddi, 2, 2, s[14:9]));
      prog.push_back(aluWord(procTypes::opAdd, 3, 1, 2));
      prog.push_back(aluWord(procTypes::opSub, 4, 1, 2));
      prog.push_back(aluWord(procTypes::opAnd, 5, 1, 2));
      prog.push_back(aluWord(procTypes::opXor, 6, 1, 2));
      prog.push_back(immWord(procTypes::opAddi, 7, 1, -20));
    end
    prog.push_back(liWord(1, -1));                           // 0xffff
    prog.push_back(immWord(procTypes::opAddi, 2, 1, 1));     // wraps to 0
    prog.push_back(aluWord(procTypes::opSub, 3, 0, 1));
    prog.push_back(aluWord(procTypes::opAdd, 4, 1, 1));
    prog.push_back(immWord(procTypes::opHalt, 0, 0, 0));
    runProgram("alu ops");

    prog.delete();
    r = nextRand();
    prog.push_back(liWord(1, r[8:0]));
    repeat (4) prog.push_back(immWord(procTypes::opAddi, 1, 1, nextRand()));
    prog.push_back(aluWord(procTypes::opAdd, 2, 1, 1));
    prog.push_back(aluWord(procTypes::opSub, 3, 2, 1));
    prog.push_back(aluWord(procTypes::opXor, 1, 3, 2));
    prog.push_back(aluWord(procTypes::opAdd, 4, 1, 3));
    prog.push_back(aluWord(procTypes::opAnd, 5, 4, 1));
    prog.push_back(immWord(procTypes::opHalt, 0, 0, 0));
    runProgram("dependent chain");

    prog.delete();
    prog.push_back(liWord(2, 5));
    prog.push_back(immWord(procTypes::opBeqz, 0, 2, 3)); // not taken
    prog.push_back(immWord(procTypes::opAddi, 3, 0, 1));
    prog.push_back(immWord(procTypes::opBeqz, 0, 1, 2)); // taken, skips two
    prog.push_back(liWord(4, 7));
    prog.push_back(liWord(5, 9));
    prog.push_back(liWord(6, 11));
    prog.push_back(immWord(procTypes::opBeqz, 0, 0, 0)); // taken onto next
    prog.push_back(immWord(procTypes::opAddi, 7, 6, 1));
    prog.push_back(immWord(procTypes::opHalt, 0, 0, 0));
    runProgram("forward branches");

    prog.delete();
    prog.push_back(liWord(1, 3));
    prog.push_back(immWord(procTypes::opAddi, 2, 1, 4));
    prog.push_back(immWord(procTypes::opHalt, 0, 0, 0));
    prog.push_back(liWord(3, 1));
    prog.push_back(aluWord(procTypes::opAdd, 4, 1, 2));
    runProgram("halt");

    prog.delete();
    prog.push_back(liWord(1, 5));
    prog.push_back(aluWord(procTypes::opAdd, 2, 1, 1));
    prog.push_back(16'hb248);                              // opcode 0xb is not defined
    prog.push_back(liWord(3, 1));
    prog.push_back(immWord(procTypes::opAddi, 4, 1, 1));
    prog.push_back(immWord(procTypes::opHalt, 0, 0, 0));
    runProgram("illegal opcode");

    prog.delete();
    for (int i = 0; i < 40; i++) begin
      r = nextRand();
      skip = int'(r[13:12]);
      if (skip > 39 - i) skip = 39 - i; // keep targets at or before the final HALT
      case (r[2:0])
        3'd0, 3'd7: prog.push_back(liWord(r[5:3], r[15:7]));
        3'd5: prog.push_back(immWord(procTypes::opAddi, r[5:3], r[8:6], r[15:10]));
        3'd6: prog.push_back(immWord(procTypes::opBeqz, 0, r[8:6], skip));
        default: prog.push_back(aluWord(procTypes::opcode'(4'(r[2:0])), r[5:3], r[8:6], r[11:9]));
      endcase
    end
    prog.push_back(immWord(procTypes::opHalt, 0, 0, 0));
    runProgram("random mix");

    $display("%0d tests, %0d failed, %0d check errors", testCount, failCount, errCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/procTypes.sv
design/pipeTypes.sv
design/fetchUnit.sv
design/regFile.sv
design/decodeUnit.sv
design/executeUnit.sv
design/proc.sv
tests/procTb.sv

// ==== Makefile ====
TOP = procTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module proc
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
